// ==== axi_lite_txn_monitor.f ====
+incdir+.
monitor_types_pkg.sv
monitor_csr_pkg.sv
stall_watchdog.sv
outstanding_tracker.sv
monitor_csr.sv
axi_lite_txn_monitor.sv
tb_axi_lite_txn_monitor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the transaction monitor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	-f axi_lite_txn_monitor.f \
	--top-module tb_axi_lite_txn_monitor \
	-o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

# The testbench prints the pass message only when every check held
if echo "$output" | grep -qx "No errors"; then
	exit 0
fi
exit 1

// ==== tb_axi_lite_txn_monitor.sv ====
`timescale 1ns/1ps
`include "monitor_settings.svh"

module tb_axi_lite_txn_monitor
	import monitor_types_pkg::*;
	import monitor_csr_pkg::*;
();

	localparam int HS_LIMIT = 16;
	localparam int TIMEOUT_CYCLES = 6000;
	localparam int STALL_QUIET = 2 * `MON_STALL_LIMIT + 5;

	logic munoc_port_4 = 1'b0;
	logic munoc_port_6;
	logic mon_awvalid, mon_awready, mon_bvalid, mon_bready;
	logic mon_arvalid, mon_arready, mon_rvalid, mon_rready;
	csr_addr_t s_awaddr;
	csr_addr_t s_araddr;
	csr_data_t s_wdata;
	csr_data_t s_rdata;
	logic s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
	logic s_arvalid, s_arready, s_rvalid, s_rready;
	logic [1:0] s_bresp;
	logic [1:0] s_rresp;

	int errors = 0;
	int cycles = 0;
	integer seed;
	// Expected state of both trackers and the CSR block
	count_t m_wr_count;
	count_t m_rd_count;
	logic m_wr_err, m_rd_err, m_wr_en, m_rd_en;

	axi_lite_txn_monitor i_axi_lite_txn_monitor (.*);

	always #5 munoc_port_4 = ~munoc_port_4;

	// Run length guard
	always @(posedge munoc_port_4)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Errors found");
			$finish;
		end
	end

	// ******************************
	// Reference model
	// ******************************

	function automatic csr_data_t status_word();
		return {16'h0, m_rd_count, m_wr_count, 4'h0, m_rd_err, m_wr_err,
			m_rd_count == count_t'(0), m_wr_count == count_t'(0)};
	endfunction

	// One tracker step for one clock of events
	task automatic model_step(input logic en, input logic up, input logic down,
		inout count_t cnt, inout logic err);
		begin
			if (en && up && !down && cnt != '1)
				cnt = cnt + count_t'(1);
			else if (en && down && !up)
			begin
				// Response with nothing outstanding
				if (cnt == count_t'(0))
					err = 1'b1;
				else
					cnt = cnt - count_t'(1);
			end
		end
	endtask

	// ******************************
	// Monitored bus stimulus
	// ******************************

	// Bits are awvalid, awready, bvalid, bready, arvalid, arready, rvalid, rready
	task automatic mon_drive(input logic [7:0] bits);
		begin
			{mon_awvalid, mon_awready, mon_bvalid, mon_bready,
				mon_arvalid, mon_arready, mon_rvalid, mon_rready} = bits;
			model_step(m_wr_en, bits[7] & bits[6], bits[5] & bits[4], m_wr_count, m_wr_err);
			model_step(m_rd_en, bits[3] & bits[2], bits[1] & bits[0], m_rd_count, m_rd_err);
			@(posedge munoc_port_4);
			#1;
			{mon_awvalid, mon_awready, mon_bvalid, mon_bready,
				mon_arvalid, mon_arready, mon_rvalid, mon_rready} = 8'h00;
		end
	endtask

	// Full handshakes on the chosen channels
	task automatic mon_event(input logic aw, input logic b, input logic ar, input logic r);
		mon_drive({aw, aw, b, b, ar, ar, r, r});
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge munoc_port_4);
			#1;
		end
	endtask

	// ******************************
	// CSR access
	// ******************************

	task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
		int n;
		begin
			n = 0;
			s_awaddr = addr;
			s_wdata = data;
			s_awvalid = 1'b1;
			s_wvalid = 1'b1;
			s_bready = 1'b1;
			@(negedge munoc_port_4);
			while (!s_awready && n < HS_LIMIT)
			begin
				@(negedge munoc_port_4);
				n++;
			end
			if (!s_awready)
			begin
				$display("CSR write to 0x%h was never accepted", addr);
				errors++;
			end
			else
				check_value("write data ready", 32'h1, 32'(s_wready));
			@(posedge munoc_port_4);
			#1;
			s_awvalid = 1'b0;
			s_wvalid = 1'b0;
			// Control and clear-on-write effects seen by the model
			if (addr == REG_CTRL)
				{m_rd_en, m_wr_en} = data[1:0];
			if (addr == REG_STATUS && data[2])
				m_wr_err = 1'b0;
			if (addr == REG_STATUS && data[3])
				m_rd_err = 1'b0;
			n = 0;
			@(negedge munoc_port_4);
			while (!s_bvalid && n < HS_LIMIT)
			begin
				@(negedge munoc_port_4);
				n++;
			end
			if (!s_bvalid)
			begin
				$display("CSR write to 0x%h got no write response", addr);
				errors++;
			end
			else
				check_value("write response", 32'h0, 32'(s_bresp));
			@(posedge munoc_port_4);
			#1;
			s_bready = 1'b0;
		end
	endtask

	task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
		int n;
		begin
			n = 0;
			s_araddr = addr;
			s_arvalid = 1'b1;
			s_rready = 1'b1;
			@(negedge munoc_port_4);
			while (!s_arready && n < HS_LIMIT)
			begin
				@(negedge munoc_port_4);
				n++;
			end
			if (!s_arready)
			begin
				$display("CSR read from 0x%h was never accepted", addr);
				errors++;
			end
			@(posedge munoc_port_4);
			#1;
			s_arvalid = 1'b0;
			n = 0;
			@(negedge munoc_port_4);
			while (!s_rvalid && n < HS_LIMIT)
			begin
				@(negedge munoc_port_4);
				n++;
			end
			if (!s_rvalid)
			begin
				$display("CSR read from 0x%h got no read data", addr);
				errors++;
			end
			else
				check_value("read response", 32'h0, 32'(s_rresp));
			data = s_rdata;
			@(posedge munoc_port_4);
			#1;
			s_rready = 1'b0;
		end
	endtask

	task automatic check_value(input string name, input csr_data_t expected,
		input csr_data_t actual);
		assert (actual === expected)
		else
		begin
			$display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			errors++;
		end
	endtask

	// One spare cycle lets sticky bits settle before the read
	task automatic expect_reg(input string name, input csr_addr_t addr,
		input csr_data_t expected);
		csr_data_t got;
		begin
			idle_cycles(1);
			csr_read(addr, got);
			check_value(name, expected, got);
		end
	endtask

	initial
	begin
		logic [31:0] rnd;
		logic [7:0] bits;
		int wr_quiet;
		int rd_quiet;
		csr_data_t rdata;

		seed = 32'hcf5d_35c3;
		wr_quiet = 0;
		rd_quiet = 0;
		{mon_awvalid, mon_awready, mon_bvalid, mon_bready} = 4'h0;
		{mon_arvalid, mon_arready, mon_rvalid, mon_rready} = 4'h0;
		{s_awvalid, s_wvalid, s_bready, s_arvalid, s_rready} = 5'h00;
		s_awaddr = '0;
		s_araddr = '0;
		s_wdata = '0;
		m_wr_count = '0;
		m_rd_count = '0;
		{m_wr_err, m_rd_err} = 2'b00;
		{m_wr_en, m_rd_en} = 2'b11;
		munoc_port_6 = 1'b0;
		repeat (8) @(posedge munoc_port_4);
		#1;
		munoc_port_6 = 1'b1;

		// Reset values and an unmapped offset
		expect_reg("reset ctrl", REG_CTRL, 32'h3);
		expect_reg("reset status", REG_STATUS, status_word());
		expect_reg("reset wr stall", REG_WR_STALL, 32'h0);
		expect_reg("reset rd stall", REG_RD_STALL, 32'h0);
		expect_reg("unmapped read", 4'h2, 32'h0);

		// Counting with both sides kept apart
		repeat (3) mon_event(1'b1, 1'b0, 1'b0, 1'b0);
		mon_event(1'b0, 1'b1, 1'b0, 1'b0);
		expect_reg("write count", REG_STATUS, status_word());
		repeat (2) mon_event(1'b0, 1'b0, 1'b1, 1'b0);
		mon_event(1'b0, 1'b0, 1'b1, 1'b1);
		expect_reg("read count", REG_STATUS, status_word());

		// Underflow on both sides and a clear of one side at a time
		repeat (2) mon_event(1'b0, 1'b1, 1'b0, 1'b1);
		mon_event(1'b0, 1'b1, 1'b0, 1'b0);
		mon_event(1'b0, 1'b0, 1'b0, 1'b1);
		expect_reg("underflow", REG_STATUS, status_word());
		csr_write(REG_STATUS, 32'h4);
		expect_reg("clear wr error", REG_STATUS, status_word());
		csr_write(REG_STATUS, 32'h8);
		expect_reg("clear rd error", REG_STATUS, status_word());

		// ******************************
		// Stall timeout on the read side
		// ******************************
		mon_event(1'b0, 1'b0, 1'b1, 1'b0);
		idle_cycles(STALL_QUIET);
		idle_cycles(1);
		csr_read(REG_RD_STALL, rdata);
		check_value("stall events", 32'h2, 32'(rdata[23:16]));
		assert (rdata[15:0] < 16'(`MON_STALL_LIMIT))
		else
		begin
			$display("[FAIL] stall wait: expected below %0d, actual %0d",
				`MON_STALL_LIMIT, rdata[15:0]);
			errors++;
		end
		m_rd_err = 1'b1;
		expect_reg("stall error", REG_STATUS, status_word());
		mon_event(1'b0, 1'b0, 1'b0, 1'b1);
		expect_reg("stall released", REG_RD_STALL, 32'h0002_0000);
		expect_reg("stall idle", REG_STATUS, status_word());
		expect_reg("write side quiet", REG_WR_STALL, 32'h0);
		csr_write(REG_STATUS, 32'hC);

		// Tracking disabled with an underflow attempt
		csr_write(REG_CTRL, 32'h0);
		mon_event(1'b1, 1'b0, 1'b1, 1'b0);
		repeat (2) mon_event(1'b0, 1'b1, 1'b0, 1'b1);
		expect_reg("disabled", REG_STATUS, status_word());
		csr_write(REG_CTRL, 32'h3);
		expect_reg("ctrl restored", REG_CTRL, 32'h3);
		mon_event(1'b1, 1'b0, 1'b1, 1'b0);
		expect_reg("enabled again", REG_STATUS, status_word());
		mon_event(1'b0, 1'b1, 1'b0, 1'b1);

		// ******************************
		// Random traffic
		// ******************************
		for (int i = 0; i < 300; i++)
		begin
			rnd = $random(seed);
			bits = rnd[7:0];
			// Never fill the counter
			if (m_wr_count >= 4'd14)
				bits[6] = 1'b0;
			if (m_rd_count >= 4'd14)
				bits[2] = 1'b0;
			// Force progress long before the stall limit
			if (wr_quiet >= 10)
				bits[7:4] = (m_wr_count >= 4'd14) ? 4'b0011 : 4'b1100;
			if (rd_quiet >= 10)
				bits[3:0] = (m_rd_count >= 4'd14) ? 4'b0011 : 4'b1100;
			wr_quiet = ((bits[7] & bits[6]) | (bits[5] & bits[4])) ? 0 : wr_quiet + 1;
			rd_quiet = ((bits[3] & bits[2]) | (bits[1] & bits[0])) ? 0 : rd_quiet + 1;
			mon_drive(bits);
		end
		expect_reg("random traffic", REG_STATUS, status_word());

		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== axi_lite_txn_monitor.sv ====
`timescale 1ns/1ps

module axi_lite_txn_monitor
	import monitor_types_pkg::*;
(
	input  logic      munoc_port_4,
	input  logic      munoc_port_6,
	// Observed bus, handshake signals only
	input  logic      mon_awvalid,
	input  logic      mon_awready,
	input  logic      mon_bvalid,
	input  logic      mon_bready,
	input  logic      mon_arvalid,
	input  logic      mon_arready,
	input  logic      mon_rvalid,
	input  logic      mon_rready,
	// Register access
	input  csr_addr_t s_awaddr,
	input  logic      s_awvalid,
	output logic      s_awready,
	input  csr_data_t s_wdata,
	input  logic      s_wvalid,
	output logic      s_wready,
	output logic[1:0] s_bresp,
	output logic      s_bvalid,
	input  logic      s_bready,
	input  csr_addr_t s_araddr,
	input  logic      s_arvalid,
	output logic      s_arready,
	output csr_data_t s_rdata,
	output logic[1:0] s_rresp,
	output logic      s_rvalid,
	input  logic      s_rready
);

	logic aw_evt, b_evt, ar_evt, r_evt;
	logic wr_enable, rd_enable;
	count_t wr_count, rd_count;
	logic wr_idle, rd_idle;
	logic wr_error, rd_error;
	wait_t wr_wait, rd_wait;
	event_t wr_events, rd_events;

	// Transfers on the observed bus
	assign aw_evt = mon_awvalid & mon_awready;
	assign b_evt  = mon_bvalid & mon_bready;
	assign ar_evt = mon_arvalid & mon_arready;
	assign r_evt  = mon_rvalid & mon_rready;

	// Write side, requests on AW and completions on B
	outstanding_tracker i_wr_tracker
	(
		.munoc_port_4 (munoc_port_4), .munoc_port_6 (munoc_port_6),
		.enable (wr_enable), .up (aw_evt), .down (b_evt),
		.count (wr_count), .idle (wr_idle), .error (wr_error),
		.wait_cycles (wr_wait), .timeout_events (wr_events)
	);

	// Read side, requests on AR and completions on R
	outstanding_tracker i_rd_tracker
	(
		.munoc_port_4 (munoc_port_4), .munoc_port_6 (munoc_port_6),
		.enable (rd_enable), .up (ar_evt), .down (r_evt),
		.count (rd_count), .idle (rd_idle), .error (rd_error),
		.wait_cycles (rd_wait), .timeout_events (rd_events)
	);

	monitor_csr i_csr (.*);

endmodule

// ==== monitor_csr.sv ====
`timescale 1ns/1ps
`include "monitor_settings.svh"

module monitor_csr
	import monitor_types_pkg::*;
	import monitor_csr_pkg::*;
(
	input  logic      munoc_port_4,
	input  logic      munoc_port_6,
	// AXI4-Lite slave
	input  csr_addr_t s_awaddr,
	input  logic      s_awvalid,
	output logic      s_awready,
	input  csr_data_t s_wdata,
	input  logic      s_wvalid,
	output logic      s_wready,
	output logic[1:0] s_bresp,
	output logic      s_bvalid,
	input  logic      s_bready,
	input  csr_addr_t s_araddr,
	input  logic      s_arvalid,
	output logic      s_arready,
	output csr_data_t s_rdata,
	output logic[1:0] s_rresp,
	output logic      s_rvalid,
	input  logic      s_rready,
	// Control to the trackers
	output logic      wr_enable,
	output logic      rd_enable,
	// Write tracker status
	input  count_t    wr_count,
	input  logic      wr_idle,
	input  logic      wr_error,
	input  wait_t     wr_wait,
	input  event_t    wr_events,
	// Read tracker status
	input  count_t    rd_count,
	input  logic      rd_idle,
	input  logic      rd_error,
	input  wait_t     rd_wait,
	input  event_t    rd_events
);

	wr_state_t wr_state;
	rd_state_t rd_state;
	logic wr_accept;
	logic rd_accept;
	logic [1:0] ctrl_q;
	logic wr_err_q;
	logic rd_err_q;
	csr_data_t read_word;

	// ******************************
	// Handshakes
	// ******************************

	// Address and data are taken in the same cycle
	assign s_awready = s_awvalid & s_wvalid & (wr_state == WR_IDLE);
	assign s_wready  = s_awready;
	assign wr_accept = s_awready;
	assign s_bvalid  = (wr_state == WR_RESP);
	assign s_bresp   = 2'b00;

	assign s_arready = (rd_state == RD_IDLE);
	assign rd_accept = s_arvalid & s_arready;
	assign s_rvalid  = (rd_state == RD_DATA);
	assign s_rresp   = 2'b00;

	always_ff @(posedge munoc_port_4 or negedge munoc_port_6)
	begin
		if (!munoc_port_6)
		begin
			wr_state <= WR_IDLE;
			rd_state <= RD_IDLE;
		end
		else
		begin
			// Held response blocks the next write
			case (wr_state)
				WR_IDLE: if (wr_accept) wr_state <= WR_RESP;
				WR_RESP: if (s_bready) wr_state <= WR_IDLE;
			endcase
			case (rd_state)
				RD_IDLE: if (rd_accept) rd_state <= RD_DATA;
				RD_DATA: if (s_rready) rd_state <= RD_IDLE;
			endcase
		end
	end

	// ******************************
	// Control and sticky errors
	// ******************************

	always_ff @(posedge munoc_port_4 or negedge munoc_port_6)
	begin
		if (!munoc_port_6)
		begin
			ctrl_q   <= 2'b11;
			wr_err_q <= 1'b0;
			rd_err_q <= 1'b0;
		end
		else
		begin
			if (wr_accept && (s_awaddr == REG_CTRL))
				ctrl_q <= s_wdata[1:0];
			// New error wins over a clear in the same cycle
			if (wr_error)
				wr_err_q <= 1'b1;
			else if (wr_accept && (s_awaddr == REG_STATUS) && s_wdata[2])
				wr_err_q <= 1'b0;
			if (rd_error)
				rd_err_q <= 1'b1;
			else if (wr_accept && (s_awaddr == REG_STATUS) && s_wdata[3])
				rd_err_q <= 1'b0;
		end
	end

	assign wr_enable = ctrl_q[0];
	assign rd_enable = ctrl_q[1];

	// Read data mux, unmapped offsets give zero
	always_comb
	begin
		read_word = '0;
		case (s_araddr)
			REG_CTRL:
				read_word[1:0] = ctrl_q;
			REG_STATUS:
			begin
				read_word[3:0] = {rd_err_q, wr_err_q, rd_idle, wr_idle};
				read_word[8 +: `MON_COUNT_BW]  = wr_count;
				read_word[12 +: `MON_COUNT_BW] = rd_count;
			end
			REG_WR_STALL:
			begin
				read_word[0 +: `MON_WAIT_BW]   = wr_wait;
				read_word[16 +: `MON_EVENT_BW] = wr_events;
			end
			REG_RD_STALL:
			begin
				read_word[0 +: `MON_WAIT_BW]   = rd_wait;
				read_word[16 +: `MON_EVENT_BW] = rd_events;
			end
			default:
				read_word = '0;
		endcase
	end

	// Captured on the address handshake and held for the response
	always_ff @(posedge munoc_port_4)
	begin
		if (rd_accept)
			s_rdata <= read_word;
	end

	a_bvalid_hold: assert property (
		@(posedge munoc_port_4) disable iff (!munoc_port_6)
		(s_bvalid && !s_bready) |=> s_bvalid
	);

	a_rdata_stable: assert property (
		@(posedge munoc_port_4) disable iff (!munoc_port_6)
		(s_rvalid && !s_rready) |=> $stable(s_rdata)
	);

endmodule

// ==== outstanding_tracker.sv ====
`timescale 1ns/1ps

module outstanding_tracker
	import monitor_types_pkg::*;
(
	input  logic   munoc_port_4,
	input  logic   munoc_port_6,
	input  logic   enable,
	input  logic   up,
	input  logic   down,
	output count_t count,
	output logic   idle,
	output logic   error,
	output wait_t  wait_cycles,
	output event_t timeout_events
);

	// Net direction of this cycle, only when enabled
	logic inc;
	logic dec;
	// Response seen with nothing outstanding
	logic underflow;
	logic timeout;

	assign inc = enable & up & ~down;
	assign dec = enable & down & ~up;

	// ******************************
	// Outstanding counter
	// ******************************

	always_ff @(posedge munoc_port_4 or negedge munoc_port_6)
	begin
		if (!munoc_port_6)
		begin
			count     <= '0;
			underflow <= 1'b0;
		end
		else
		begin
			underflow <= dec && (count == '0);
			// Saturates at both ends, up and down together cancel
			if (inc && (count != '1))
				count <= count + 1'b1;
			else if (dec && (count != '0))
				count <= count - 1'b1;
		end
	end

	assign idle = (count == '0);

	// Underflow and stall share one error line
	assign error = underflow | timeout;

	// ******************************
	// Stall detection
	// ******************************

	stall_watchdog i_watchdog
	(
		.munoc_port_4   (munoc_port_4),
		.munoc_port_6   (munoc_port_6),
		.enable         (enable),
		.busy           (~idle),
		.activity       (up | down),
		.timeout        (timeout),
		.wait_cycles    (wait_cycles),
		.timeout_events (timeout_events)
	);

	// More requests than the counter can hold
	a_no_overflow: assert property (
		@(posedge munoc_port_4) disable iff (!munoc_port_6)
		inc |-> (count != '1)
	);

endmodule

// ==== stall_watchdog.sv ====
`timescale 1ns/1ps
`include "monitor_settings.svh"

module stall_watchdog
	import monitor_types_pkg::*;
(
	input  logic   munoc_port_4,
	input  logic   munoc_port_6,
	input  logic   enable,
	input  logic   busy,
	input  logic   activity,
	output logic   timeout,
	output wait_t  wait_cycles,
	output event_t timeout_events
);

	// Value held one cycle before the limit would be reached
	localparam wait_t LAST_WAIT = wait_t'(`MON_STALL_LIMIT - 1);

	logic at_limit;

	assign at_limit = (wait_cycles == LAST_WAIT);

	always_ff @(posedge munoc_port_4 or negedge munoc_port_6)
	begin
		if (!munoc_port_6)
		begin
			timeout        <= 1'b0;
			wait_cycles    <= '0;
			timeout_events <= '0;
		end
		else
		begin
			// Single cycle pulse by default
			timeout <= 1'b0;
			if (enable)
			begin
				// Nothing outstanding, nothing to wait for
				if (!busy)
					wait_cycles <= '0;
				// Progress on the bus restarts the measure
				else if (activity)
					wait_cycles <= '0;
				// Limit reached: fire and start a new window
				else if (at_limit)
				begin
					timeout     <= 1'b1;
					wait_cycles <= '0;
					if (timeout_events != '1)
						timeout_events <= timeout_events + 1'b1;
				end
				else
					wait_cycles <= wait_cycles + 1'b1;
			end
		end
	end

	// A timeout only follows a cycle with outstanding work
	a_timeout_after_busy: assert property (
		@(posedge munoc_port_4) disable iff (!munoc_port_6)
		timeout |-> $past(busy)
	);

endmodule

// ==== monitor_csr_pkg.sv ====
// Register map and handshake FSM states of the CSR slave
package monitor_csr_pkg;

	import monitor_types_pkg::*;

	// Word aligned register offsets
	typedef enum csr_addr_t
	{
		// Enable bits
		REG_CTRL     = 'h0,
		// Idle, sticky errors and counts
		REG_STATUS   = 'h4,
		// Write side watchdog
		REG_WR_STALL = 'h8,
		// Read side watchdog
		REG_RD_STALL = 'hC
	} reg_offset_t;

	// Write channel, AW and W taken together
	typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;

	// Read channel
	typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

endpackage

// ==== monitor_types_pkg.sv ====
`include "monitor_settings.svh"

// Vector types shared by the trackers, the CSR block and the top level
package monitor_types_pkg;

	// Outstanding count of one direction
	typedef logic [`MON_COUNT_BW-1:0] count_t;

	// Inactive busy cycles since last progress
	typedef logic [`MON_WAIT_BW-1:0] wait_t;

	// Timeout event counter
	typedef logic [`MON_EVENT_BW-1:0] event_t;

	// ******************************
	// Register interface
	// ******************************

	// Read and write data word
	typedef logic [`MON_DATA_BW-1:0] csr_data_t;

	// Byte address inside the register block
	typedef logic [`MON_ADDR_BW-1:0] csr_addr_t;

endpackage

// ==== monitor_settings.svh ====
`ifndef MONITOR_SETTINGS_SVH
`define MONITOR_SETTINGS_SVH

// ******************************
// Transaction tracking widths
// ******************************

// Outstanding transaction count per direction
`define MON_COUNT_BW 4
// Inactive cycle counter inside the watchdog
`define MON_WAIT_BW 16
// Number of timeouts seen, saturating
`define MON_EVENT_BW 8

// Inactive busy cycles that make one timeout
`define MON_STALL_LIMIT 40

// ******************************
// Register interface widths
// ******************************

// Byte address, four word registers
`define MON_ADDR_BW 4
`define MON_DATA_BW 32

`endif
